// ==== design/line_refill_pkg.sv ====
package line_refill_pkg;

    // ##########################################################
    // Widths
    // ##########################################################

    localparam int unsigned ADDR_WIDTH       = 32;
    localparam int unsigned LINE_WIDTH       = 128;
    localparam int unsigned LINE_OFFSET_BITS = 4;     // 16-byte lines

    // ##########################################################
    // Data window remap
    // ##########################################################

    localparam int unsigned WINDOW_SEL_LSB  = 16;    // Address bits 19:16 select the window
    localparam int unsigned WINDOW_SEL_BITS = 4;
    localparam logic [ADDR_WIDTH-1:0] DATA_WINDOW_BASE = 32'h0000_0800;

    // ##########################################################
    // Port types
    // ##########################################################

    typedef struct packed {
        logic                  cs;
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic [LINE_WIDTH-1:0] rdata;
    } line_rsp_t;

    typedef enum logic [1:0] {
        GRANT_IDLE  = 2'd0,
        GRANT_INSTR = 2'd1,
        GRANT_DATA  = 2'd2
    } grant_state_e;

endpackage

// ==== design/refill_arbiter.sv ====
`timescale 1ns/1ps

module refill_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  line_refill_pkg::line_req_t instr_req_i,
    input  line_refill_pkg::line_req_t data_req_i,
    output line_refill_pkg::line_rsp_t instr_rsp_o,
    output line_refill_pkg::line_rsp_t data_rsp_o,

    output line_refill_pkg::line_req_t mem_req_o,
    input  line_refill_pkg::line_rsp_t mem_rsp_i
);
    import line_refill_pkg::*;

    grant_state_e          state_q;
    grant_state_e          state_d;

    logic                  data_rd;
    logic                  in_window;
    logic [ADDR_WIDTH-1:0] data_line;
    logic [ADDR_WIDTH-1:0] data_addr;

    // ##########################################################
    // Data address remap
    // ##########################################################

    assign data_rd   = data_req_i.cs & ~data_req_i.we;
    assign in_window = (data_req_i.addr[WINDOW_SEL_LSB +: WINDOW_SEL_BITS] == '0);

    assign data_line = {data_req_i.addr[ADDR_WIDTH-1:LINE_OFFSET_BITS],
                        {LINE_OFFSET_BITS{1'b0}}};

    assign data_addr = in_window ? (data_line + DATA_WINDOW_BASE)
                                 : data_req_i.addr;

    // ##########################################################
    // Request path
    // ##########################################################

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.wdata = data_req_i.wdata;      // Only the data side writes

        if (instr_req_i.cs) begin                // Fixed priority
            mem_req_o.cs   = 1'b1;
            mem_req_o.addr = instr_req_i.addr;
        end else if (data_req_i.cs) begin
            mem_req_o.cs   = 1'b1;
            mem_req_o.we   = data_req_i.we;
            mem_req_o.addr = data_addr;
        end
    end

    // ##########################################################
    // Grant state
    // ##########################################################

    always_comb begin
        state_d = state_q;

        case (state_q)
            GRANT_IDLE: begin
                if (instr_req_i.cs) begin
                    state_d = GRANT_INSTR;
                end else if (data_rd) begin
                    state_d = GRANT_DATA;
                end
            end

            GRANT_INSTR: begin
                if (instr_req_i.cs) begin
                    state_d = GRANT_INSTR;         // Held until after its rvalid
                end else if (data_rd) begin
                    state_d = GRANT_DATA;          // Waiting data read takes over
                end else begin
                    state_d = GRANT_IDLE;
                end
            end

            GRANT_DATA: begin
                if (data_rd) begin
                    state_d = GRANT_DATA;          // Read in flight keeps ownership
                end else if (instr_req_i.cs) begin
                    state_d = GRANT_INSTR;
                end else begin
                    state_d = GRANT_IDLE;
                end
            end

            default: begin
                state_d = GRANT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= GRANT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ##########################################################
    // Response steering
    // ##########################################################

    always_comb begin
        instr_rsp_o = '0;
        data_rsp_o  = '0;

        case (state_q)
            GRANT_INSTR: begin
                instr_rsp_o = mem_rsp_i;
            end
            GRANT_DATA: begin
                data_rsp_o = mem_rsp_i;
            end
            default: begin
                instr_rsp_o = '0;
                data_rsp_o  = '0;
            end
        endcase
    end

endmodule

// ==== design/line_memory.sv ====
`timescale 1ns/1ps

module line_memory #(
    parameter int unsigned MEM_LINES    = 1024,
    parameter int unsigned READ_LATENCY = 3
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  line_refill_pkg::line_req_t req_i,
    output line_refill_pkg::line_rsp_t rsp_o
);
    import line_refill_pkg::*;

    localparam int unsigned IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
    localparam int unsigned CNT_W = $clog2(READ_LATENCY + 1);

    logic [LINE_WIDTH-1:0] mem_q [MEM_LINES];

    logic [IDX_W-1:0]      line_idx;
    logic [IDX_W-1:0]      rd_idx_q;
    logic [CNT_W-1:0]      busy_cnt_q;
    logic                  rvalid_q;
    logic [LINE_WIDTH-1:0] rdata_q;
    logic                  rd_accept;
    logic                  wr_en;

    assign line_idx = IDX_W'((req_i.addr >> LINE_OFFSET_BITS) % ADDR_WIDTH'(MEM_LINES));

    // No new read while one is in flight or being returned
    assign rd_accept = req_i.cs & ~req_i.we & (busy_cnt_q == '0) & ~rvalid_q;
    assign wr_en     = req_i.cs & req_i.we;

    // ##########################################################
    // Read latency counter
    // ##########################################################

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_cnt_q <= '0;
            rvalid_q   <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            if (rd_accept) begin
                busy_cnt_q <= CNT_W'(READ_LATENCY);
            end else if (busy_cnt_q != '0) begin
                busy_cnt_q <= busy_cnt_q - 1'b1;
                if (busy_cnt_q == CNT_W'(1)) begin
                    rvalid_q <= 1'b1;                  // Line goes out on the last count
                end
            end
        end
    end

    // ##########################################################
    // Storage and read data
    // ##########################################################

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[line_idx] <= req_i.wdata;
        end
        if (rd_accept) begin
            rd_idx_q <= line_idx;
        end
        if (busy_cnt_q == CNT_W'(1)) begin
            rdata_q <= mem_q[rd_idx_q];
        end
    end

    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;

endmodule

// ==== design/refill_subsys_top.sv ====
`timescale 1ns/1ps

module refill_subsys_top #(
    parameter int unsigned MEM_LINES    = 1024,
    parameter int unsigned READ_LATENCY = 3     // Minimum 1
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  line_refill_pkg::line_req_t instr_req_i,
    input  line_refill_pkg::line_req_t data_req_i,
    output line_refill_pkg::line_rsp_t instr_rsp_o,
    output line_refill_pkg::line_rsp_t data_rsp_o
);
    import line_refill_pkg::*;

    line_req_t mem_req;
    line_rsp_t mem_rsp;

    // ##########################################################
    // Port arbitration
    // ##########################################################

    refill_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .instr_req_i (instr_req_i),
        .data_req_i  (data_req_i),
        .instr_rsp_o (instr_rsp_o),
        .data_rsp_o  (data_rsp_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    // ##########################################################
    // Backing store
    // ##########################################################

    line_memory #(
        .MEM_LINES    (MEM_LINES),
        .READ_LATENCY (READ_LATENCY)
    ) u_memory (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (mem_req),
        .rsp_o  (mem_rsp)
    );

endmodule

// ==== sim/tb_refill_subsys.sv ====
`timescale 1ns/1ps

module tb_refill_subsys;
    import line_refill_pkg::*;

    localparam int unsigned MEM_LINES       = 1024;
    localparam int unsigned READ_LATENCY    = 3;
    localparam int unsigned WRRD_PAIRS      = 8;
    localparam int unsigned PRELOAD_READS   = 8;
    localparam int unsigned BOTH_ROUNDS     = 4;
    localparam int unsigned MIX_TXNS        = 200;
    localparam int unsigned NUM_TXNS        = MEM_LINES + 2 * WRRD_PAIRS + 2 + PRELOAD_READS
                                            + 2 * BOTH_ROUNDS + MIX_TXNS;
    localparam int unsigned TIMEOUT_CYCLES  = 40 * NUM_TXNS + 100;
    localparam int unsigned READ_WAIT_LIMIT = 40;

    logic                  clk;
    logic                  rst_n;
    line_req_t             instr_req;
    line_req_t             data_req;
    line_rsp_t             instr_rsp;
    line_rsp_t             data_rsp;

    logic [LINE_WIDTH-1:0] shadow [MEM_LINES];       // Reference copy of the store
    logic [31:0]           lfsr_q;
    int unsigned           cycle_cnt;
    int unsigned           value_errors;
    int unsigned           protocol_errors;
    int unsigned           reads_checked;
    logic                  instr_pending;
    logic                  data_pending;
    int unsigned           instr_exp_idx;
    int unsigned           data_exp_idx;
    int unsigned           instr_done_cycle;
    int unsigned           data_done_cycle;
    logic [LINE_WIDTH-1:0] exp_line;
    grant_state_e          grant_now;
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [1:0]            op_sel;

    refill_subsys_top #(
        .MEM_LINES    (MEM_LINES),
        .READ_LATENCY (READ_LATENCY)
    ) uut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .instr_req_i (instr_req),
        .data_req_i  (data_req),
        .instr_rsp_o (instr_rsp),
        .data_rsp_o  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##########################################################
    // Random source and reference model
    // ##########################################################

    // Taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [LINE_WIDTH-1:0] take_bits(input int unsigned n);
        logic [LINE_WIDTH-1:0] v;
        logic                  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[LINE_WIDTH-2:0], fb};
        end
        return v;
    endfunction

    function automatic int unsigned phys_index(input logic is_data,
                                               input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] a;
        a = addr;
        if (is_data && addr[19:16] == 4'h0) begin
            a = {addr[ADDR_WIDTH-1:LINE_OFFSET_BITS], 4'h0} + DATA_WINDOW_BASE;  // Low window
        end
        return (a >> LINE_OFFSET_BITS) % MEM_LINES;
    endfunction

    // ##########################################################
    // Drivers
    // ##########################################################

    task automatic write_line(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [LINE_WIDTH-1:0] line);
        line_req_t req;
        req       = '0;
        req.cs    = 1'b1;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = line;
        @(posedge clk);
        data_req <= req;                             // Single-cycle write
        shadow[phys_index(1'b1, addr)] = line;
        @(posedge clk);
        data_req <= '0;
    endtask

    task automatic read_line(input logic is_data, input logic [ADDR_WIDTH-1:0] addr,
                             input logic check_latency);
        line_req_t   req;
        int unsigned edges;
        logic        seen;
        req      = '0;
        req.cs   = 1'b1;
        req.addr = addr;
        edges    = 0;
        seen     = 1'b0;
        @(posedge clk);
        if (is_data) begin
            data_req     <= req;
            data_exp_idx  = phys_index(1'b1, addr);
            data_pending  = 1'b1;
        end else begin
            instr_req     <= req;
            instr_exp_idx  = phys_index(1'b0, addr);
            instr_pending  = 1'b1;
        end
        while (!seen && edges < READ_WAIT_LIMIT) begin
            @(negedge clk);
            seen = is_data ? data_rsp.rvalid : instr_rsp.rvalid;
            if (!seen) begin
                @(posedge clk);
                edges = edges + 1;
            end
        end
        if (!seen) begin
            $display("No rvalid on the %s port for address %h within %0d cycles",
                     is_data ? "data" : "instruction", addr, READ_WAIT_LIMIT);
            protocol_errors = protocol_errors + 1;
            if (is_data) data_pending = 1'b0;
            else instr_pending = 1'b0;
        end else if (check_latency && edges != READ_LATENCY + 1) begin
            // One edge to accept the read, then READ_LATENCY edges to rvalid
            $display("** Error: %s latency expected %h got %h",
                     is_data ? "data_rsp_o.rvalid" : "instr_rsp_o.rvalid",
                     READ_LATENCY + 1, edges);
            value_errors = value_errors + 1;
        end
        @(posedge clk);
        req.cs = 1'b0;
        if (is_data) data_req <= req;
        else instr_req <= req;
    endtask

    // ##########################################################
    // Response monitor
    // ##########################################################

    always @(negedge clk) begin
        if (rst_n) begin
            grant_now = grant_state_e'(uut.u_arbiter.state_q);
            if (instr_pending && data_rsp !== '0) begin          // Data side reads zero
                $display("** Error: data_rsp_o expected %h got %h (grant %s)",
                         {($bits(line_rsp_t)){1'b0}}, data_rsp, grant_now.name());
                value_errors = value_errors + 1;
            end
            if (instr_rsp.rvalid) begin
                if (!instr_pending) begin
                    $display("Unexpected rvalid on the instruction port at cycle %0d", cycle_cnt);
                    protocol_errors = protocol_errors + 1;
                end else begin
                    exp_line = shadow[instr_exp_idx];
                    if (instr_rsp.rdata !== exp_line) begin
                        $display("** Error: instr_rsp_o.rdata expected %h got %h (grant %s)",
                                 exp_line, instr_rsp.rdata, grant_now.name());
                        value_errors = value_errors + 1;
                    end
                    instr_pending    = 1'b0;
                    instr_done_cycle = cycle_cnt;
                    reads_checked    = reads_checked + 1;
                end
            end
            if (data_rsp.rvalid) begin
                if (!data_pending) begin
                    $display("Unexpected rvalid on the data port at cycle %0d", cycle_cnt);
                    protocol_errors = protocol_errors + 1;
                end else begin
                    exp_line = shadow[data_exp_idx];
                    if (data_rsp.rdata !== exp_line) begin
                        $display("** Error: data_rsp_o.rdata expected %h got %h (grant %s)",
                                 exp_line, data_rsp.rdata, grant_now.name());
                        value_errors = value_errors + 1;
                    end
                    data_pending    = 1'b0;
                    data_done_cycle = cycle_cnt;
                    reads_checked   = reads_checked + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, a transaction never finished", cycle_cnt);
            $display("Reads checked %0d, value errors %0d, protocol errors %0d",
                     reads_checked, value_errors, protocol_errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ##########################################################
    // Stimulus
    // ##########################################################

    initial begin
        lfsr_q          = 32'd82037;
        cycle_cnt       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        reads_checked   = 0;
        instr_pending   = 1'b0;
        data_pending    = 1'b0;
        rst_n           = 1'b0;
        instr_req       = '0;
        data_req        = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        repeat (20) @(posedge clk);                   // Idle stretch where no rvalid may appear

        for (int i = 0; i < MEM_LINES; i++) begin     // Fill every line outside the window
            write_line(32'h0001_0000 + (i << LINE_OFFSET_BITS), take_bits(LINE_WIDTH));
        end

        for (int i = 0; i < WRRD_PAIRS; i++) begin
            addr_a = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
            if (addr_a[19:16] == 4'h0) addr_a[16] = 1'b1;
            write_line(addr_a, take_bits(LINE_WIDTH));
            read_line(1'b1, addr_a, 1'b1);
        end

        write_line(32'h0000_0123, take_bits(LINE_WIDTH));   // Lands at 0x920
        read_line(1'b0, 32'h0000_0920, 1'b1);

        for (int i = 0; i < PRELOAD_READS; i++) begin
            read_line(1'b0, ADDR_WIDTH'(take_bits(ADDR_WIDTH)), 1'b1);
        end

        for (int i = 0; i < BOTH_ROUNDS; i++) begin
            addr_a = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
            addr_b = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
            if (phys_index(1'b1, addr_b) == phys_index(1'b0, addr_a)) addr_b[4] = ~addr_b[4];
            instr_done_cycle = 0;
            data_done_cycle  = 0;
            fork
                read_line(1'b0, addr_a, 1'b0);
                read_line(1'b1, addr_b, 1'b0);
            join
            if (instr_done_cycle != 0 && data_done_cycle != 0
                && instr_done_cycle >= data_done_cycle) begin
                $display("Data rvalid arrived before the instruction rvalid in round %0d", i);
                protocol_errors = protocol_errors + 1;
            end
        end

        for (int i = 0; i < MIX_TXNS; i++) begin
            op_sel = 2'(take_bits(2));
            addr_a = ADDR_WIDTH'(take_bits(ADDR_WIDTH));
            case (op_sel)
                2'd2:    read_line(1'b1, addr_a, 1'b1);
                2'd3:    write_line(addr_a, take_bits(LINE_WIDTH));
                default: read_line(1'b0, addr_a, 1'b1);
            endcase
        end

        repeat (5) @(posedge clk);
        $display("Reads checked %0d, value errors %0d, protocol errors %0d",
                 reads_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== refill_subsys.f ====
design/line_refill_pkg.sv
design/refill_arbiter.sv
design/line_memory.sv
design/refill_subsys_top.sv
sim/tb_refill_subsys.sv

// ==== Bender.yml ====
package:
  name: refill_subsys

dependencies: {}

sources:
  # Shared package first, then the RTL
  - design/line_refill_pkg.sv
  - design/refill_arbiter.sv
  - design/line_memory.sv
  - design/refill_subsys_top.sv

  - target: simulation
    files:
      - sim/tb_refill_subsys.sv

Since the reply must open with the single word FILES, this note sits at the end. The testbench preloads all 1024 memory lines through data writes before any reads. The store is not cleared at reset, so reading an unwritten line would return X. The preload makes the run longer. The timeout limit counts those writes as transactions.
